// File: pu_core.f
src/pu_data_pkg.sv
src/pu_code_pkg.sv
src/pu_bus_if.sv
src/pu_control.sv
src/pu_multiplier.sv
src/pu_accum.sv
src/pu_fram.sv
src/pu_io.sv
src/pu_core.sv
test/pu_core_checks.sv
test/pu_core_tb.sv

// File: test/pu_core_tb.sv
`default_nettype none

module pu_core_tb;
    import pu_data_pkg::*;
    import pu_code_pkg::*;

    localparam logic [unit_count-1:0] mult_u  = 4'b0001 << unit_mult;
    localparam logic [unit_count-1:0] accum_u = 4'b0001 << unit_accum;
    localparam logic [unit_count-1:0] fram_u  = 4'b0001 << unit_fram;
    localparam logic [unit_count-1:0] io_u    = 4'b0001 << unit_io;
    localparam logic [unit_count-1:0] no_u    = 4'b0000;
    localparam int cycle_limit = 300;  // three loads and five runs fit well inside this.

    logic       clk = 1'b0;
    logic       rst;
    logic       prog_wr;
    pc_t        prog_addr;
    code_t      prog_data;
    logic       start;
    logic       in_load;
    data_t      in_data;
    attr_t      in_attr;
    logic       out_valid;
    data_t      out_data;
    attr_t      out_attr;
    logic       done;
    pc_t        stop_pc;
    code_t      prog_q [$];
    integer     seed;
    int         cycles = 0;

    always #50 clk = ~clk;

    pu_core dut0 (
        .clk (clk), .rst (rst), .prog_wr (prog_wr), .prog_addr (prog_addr),
        .prog_data (prog_data), .start (start), .in_load (in_load), .in_data (in_data),
        .in_attr (in_attr), .out_valid (out_valid), .out_data (out_data),
        .out_attr (out_attr), .done (done)
    );

    pu_core_checks checks0 (
        .clk (clk), .rst (rst), .start (start), .done (done), .out_valid (out_valid),
        .out_data (out_data), .out_attr (out_attr), .stop_pc (stop_pc)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("run stopped after %0d cycles without finishing", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // reference model and stimulus helpers
    // ----------------------------------------------------------------------
    function automatic logic fits_half(input data_t x);
        return x[31:16] == {16{x[15]}};
    endfunction

    function automatic data_t mult_expect(input data_t a, input data_t b);
        logic signed [31:0] p;
        p = $signed(a[15:0]) * $signed(b[15:0]);
        return data_t'(p >>> scale_power);
    endfunction

    function automatic logic add_overflows(input data_t a, input data_t b);
        longint s;
        s = longint'($signed(a)) + longint'($signed(b));
        return s != longint'($signed(s[31:0]));  // the sum must survive truncation.
    endfunction

    function automatic data_t half_rand();
        data_t r;
        r = $random(seed);
        return {{16{r[15]}}, r[15:0]};
    endfunction

    task automatic add_word(input logic [3:0] wr, input logic [3:0] oe,
                            input fram_addr_t addr, input logic acc_new, input logic stop);
        code_t w;
        w = '0;
        w[code_wr_lsb +: unit_count] = wr;
        w[code_oe_lsb +: unit_count] = oe;
        w[code_fram_lsb +: $bits(fram_addr_t)] = addr;
        w[code_acc_new_bit] = acc_new;
        w[code_stop_bit]    = stop;
        prog_q.push_back(w);
    endtask

    task automatic load_program();
        foreach (prog_q[i]) begin
            @(posedge clk);
            prog_wr   <= 1'b1;
            prog_addr <= pc_t'(i);
            prog_data <= prog_q[i];
        end
        @(posedge clk);
        prog_wr <= 1'b0;
        stop_pc <= pc_t'(prog_q.size() - 1);  // every program ends on its last word.
        prog_q.delete();
    endtask

    task automatic push_input(input data_t data, input attr_t attr);
        @(posedge clk);
        in_load <= 1'b1;
        in_data <= data;
        in_attr <= attr;
    endtask

    task automatic start_and_wait();
        @(posedge clk);
        in_load <= 1'b0;
        start   <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        do begin
            @(posedge clk);
        end while (!done);
    endtask

    task automatic mult_pair(input data_t a, input attr_t a_attr,
                             input data_t b, input attr_t b_attr);
        attr_t e;
        push_input(a, a_attr);
        push_input(b, b_attr);
        e = '0;
        e[invalid_bit] = a_attr[invalid_bit] || b_attr[invalid_bit]
                       || !fits_half(a) || !fits_half(b);
        checks0.expect_result(mult_expect(a, b), e);
    endtask

    task automatic accum_run(input data_t v0, input data_t v1, input data_t v2);
        data_t s1;
        data_t s2;
        logic  inv1;
        attr_t e;
        push_input(v0, '0);
        push_input(v1, '0);
        push_input(v2, '0);
        s1   = v0 + v1;
        inv1 = add_overflows(v0, v1);
        s2   = s1 + v2;
        e    = '0;
        e[invalid_bit] = inv1;
        checks0.expect_result(s1, e);
        e[invalid_bit] = inv1 || add_overflows(s1, v2);  // the flag is sticky.
        checks0.expect_result(s2, e);
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        data_t a;
        data_t b;
        data_t c;
        data_t cell_d [4];
        attr_t cell_a [4];
        attr_t bad;
        seed      = 32'h46ef_e14a;
        bad       = '0;
        bad[invalid_bit] = 1'b1;
        rst       = 1'b1;
        prog_wr   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        start     = 1'b0;
        in_load   = 1'b0;
        in_data   = '0;
        in_attr   = '0;
        stop_pc   = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // each run makes two products with two idle words before each read.
        for (int p = 0; p < 2; p++) begin
            add_word(mult_u, io_u, 2'd0, 1'b0, 1'b0);
            add_word(mult_u, io_u, 2'd0, 1'b0, 1'b0);
            add_word(no_u, no_u, 2'd0, 1'b0, 1'b0);
            add_word(no_u, no_u, 2'd0, 1'b0, 1'b0);
            add_word(io_u, mult_u, 2'd0, 1'b0, p == 1);
        end
        load_program();
        a = half_rand();
        b = half_rand();
        mult_pair(a, '0, b, '0);
        a = half_rand();
        b = half_rand();
        mult_pair(a, '0, b, '0);
        start_and_wait();

        a = half_rand();
        mult_pair(32'h0001_0003, '0, a, '0);  // upper half is no sign extension.
        a = half_rand();
        b = half_rand();
        mult_pair(a, bad, b, '0);
        start_and_wait();

        add_word(accum_u, io_u, 2'd0, 1'b1, 1'b0);
        add_word(accum_u, io_u, 2'd0, 1'b0, 1'b0);
        add_word(io_u, accum_u, 2'd0, 1'b0, 1'b0);
        add_word(accum_u, io_u, 2'd0, 1'b0, 1'b0);
        add_word(io_u, accum_u, 2'd0, 1'b0, 1'b1);
        load_program();
        a = $random(seed) >>> 2;
        b = $random(seed) >>> 2;
        c = $random(seed) >>> 2;
        accum_run(a, b, c);
        start_and_wait();
        accum_run(32'h7000_0000, 32'h2000_0000, 32'h0000_0001);
        start_and_wait();

        for (int i = 0; i < 4; i++) begin
            add_word(fram_u, io_u, fram_addr_t'(i), 1'b0, 1'b0);
        end
        for (int i = 3; i >= 0; i--) begin
            add_word(io_u, fram_u, fram_addr_t'(i), 1'b0, i == 0);
        end
        load_program();
        for (int i = 0; i < 4; i++) begin
            cell_d[i] = $random(seed);
            cell_a[i] = attr_t'($random(seed));
            push_input(cell_d[i], cell_a[i]);
        end
        for (int i = 3; i >= 0; i--) begin
            checks0.expect_result(cell_d[i], cell_a[i]);
        end
        start_and_wait();

        repeat (2) @(posedge clk);
        $display("value errors: %0d, sequence errors: %0d",
                 checks0.value_errors, checks0.seq_errors);
        if (checks0.value_errors == 0 && checks0.seq_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/pu_core_checks.sv
`default_nettype none

module pu_core_checks (
    input logic               clk,
    input logic               rst,
    input logic               start,
    input logic               done,
    input logic               out_valid,
    input pu_data_pkg::data_t out_data,
    input pu_data_pkg::attr_t out_attr,
    input pu_code_pkg::pc_t   stop_pc
);
    import pu_data_pkg::*;
    import pu_code_pkg::*;

    data_t exp_data [$];
    attr_t exp_attr [$];
    logic  active = 1'b0;       // from the start edge until done is seen.
    int    run_cycles = 0;
    int    value_errors = 0;
    int    seq_errors = 0;

    task automatic expect_result(input data_t data, input attr_t attr);
        exp_data.push_back(data);
        exp_attr.push_back(attr);
    endtask

    // ----------------------------------------------------------------------
    // result beats and program sequencing
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            run_cycles <= 0;
        end else begin
            if (out_valid) begin
                a_beat_expected: assert (active && exp_data.size() > 0) else begin
                    $display("out_valid pulse at time %0t with no io write pending", $time);
                    seq_errors++;
                end
                if (exp_data.size() > 0) begin
                    a_out_data: assert (out_data === exp_data[0]) else begin
                        $display("Error: out_data = 0x%08h, expected 0x%08h",
                                 out_data, exp_data[0]);
                        value_errors++;
                    end
                    a_out_attr: assert (out_attr === exp_attr[0]) else begin
                        $display("Error: out_attr = 0x%01h, expected 0x%01h",
                                 out_attr, exp_attr[0]);
                        value_errors++;
                    end
                    void'(exp_data.pop_front());
                    void'(exp_attr.pop_front());
                end
            end
            if (active) begin
                // the stop word at pc s shows done on the (s+2)th edge after start.
                a_done_at_stop: assert (done == (run_cycles == int'(stop_pc) + 1)) else begin
                    $display("done does not follow the stop word at pc %0d (run cycle %0d)",
                             stop_pc, run_cycles);
                    seq_errors++;
                end
                if (done) begin
                    a_all_beats: assert (exp_data.size() == 0) else begin
                        $display("program ended with %0d io results never delivered",
                                 exp_data.size());
                        seq_errors++;
                    end
                    active <= 1'b0;
                end
                run_cycles <= run_cycles + 1;
            end else begin
                a_no_idle_done: assert (!done) else begin
                    $display("done pulse while the control is idle");
                    seq_errors++;
                end
                if (start) begin
                    active     <= 1'b1;
                    run_cycles <= 0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pu_core.sv
`default_nettype none

module pu_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               prog_wr,
    input  pu_code_pkg::pc_t   prog_addr,
    input  pu_code_pkg::code_t prog_data,
    input  logic               start,
    input  logic               in_load,
    input  pu_data_pkg::data_t in_data,
    input  pu_data_pkg::attr_t in_attr,
    output logic               out_valid,
    output pu_data_pkg::data_t out_data,
    output pu_data_pkg::attr_t out_attr,
    output logic               done
);
    import pu_code_pkg::*;

    fram_addr_t fram_addr;
    logic       acc_new;

    pu_bus_if mult_bus ();
    pu_bus_if accum_bus ();
    pu_bus_if fram_bus ();
    pu_bus_if io_bus ();

    pu_control control0 (
        .clk       (clk),
        .rst       (rst),
        .prog_wr   (prog_wr),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .start     (start),
        .done      (done),
        .fram_addr (fram_addr),
        .acc_new   (acc_new),
        .mult_bus  (mult_bus.ctrl),
        .accum_bus (accum_bus.ctrl),
        .fram_bus  (fram_bus.ctrl),
        .io_bus    (io_bus.ctrl)
    );

    pu_multiplier mult0 (
        .clk (clk),
        .rst (rst),
        .bus (mult_bus.pu)
    );

    pu_accum accum0 (
        .clk     (clk),
        .rst     (rst),
        .acc_new (acc_new),
        .bus     (accum_bus.pu)
    );

    pu_fram fram0 (
        .clk       (clk),
        .rst       (rst),
        .fram_addr (fram_addr),
        .bus       (fram_bus.pu)
    );

    pu_io io0 (
        .clk       (clk),
        .rst       (rst),
        .in_load   (in_load),
        .in_data   (in_data),
        .in_attr   (in_attr),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_attr  (out_attr),
        .bus       (io_bus.pu)
    );

endmodule

`default_nettype wire

// File: src/pu_io.sv
`default_nettype none

module pu_io (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_load,
    input  pu_data_pkg::data_t   in_data,
    input  pu_data_pkg::attr_t   in_attr,
    output logic                 out_valid,
    output pu_data_pkg::data_t   out_data,
    output pu_data_pkg::attr_t   out_attr,
    pu_bus_if.pu                 bus
);
    import pu_data_pkg::*;

    data_t      q_data [queue_depth];
    attr_t      q_attr [queue_depth];
    queue_ptr_t wr_ptr;
    queue_ptr_t rd_ptr;
    logic [$clog2(queue_depth):0] count;
    logic       pop;

    assign pop = bus.signal_oe;  // a read takes the head off the queue.

    always_ff @(posedge clk) begin
        if (in_load) begin
            q_data[wr_ptr] <= in_data;
            q_attr[wr_ptr] <= in_attr;
        end
        if (bus.signal_wr) begin
            out_data <= bus.data_in;
            out_attr <= bus.attr_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            wr_ptr    <= wr_ptr + queue_ptr_t'(in_load);
            rd_ptr    <= rd_ptr + queue_ptr_t'(pop);
            count     <= count + in_load - pop;
            out_valid <= bus.signal_wr;
        end
    end

    assign bus.data_out = bus.signal_oe ? q_data[rd_ptr] : '0;
    assign bus.attr_out = bus.signal_oe ? q_attr[rd_ptr] : '0;

    a_no_overfill: assert property (
        @(posedge clk) disable iff (rst) in_load |-> count != queue_depth
    ) else $error("pu_io: push into a full input queue");

    a_no_underrun: assert property (
        @(posedge clk) disable iff (rst) pop |-> count != 0
    ) else $error("pu_io: io read with an empty input queue");

endmodule

`default_nettype wire

// File: src/pu_fram.sv
`default_nettype none

module pu_fram (
    input  logic                    clk,
    input  logic                    rst,
    input  pu_code_pkg::fram_addr_t fram_addr,
    pu_bus_if.pu                    bus
);
    import pu_code_pkg::*;
    import pu_data_pkg::*;

    data_t cell_data [fram_cells];
    attr_t cell_attr [fram_cells];
    logic [fram_cells-1:0] cell_written;
    attr_t read_attr;

    always_ff @(posedge clk) begin
        if (bus.signal_wr) begin
            cell_data[fram_addr] <= bus.data_in;
            cell_attr[fram_addr] <= bus.attr_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cell_written <= '0;
        end else if (bus.signal_wr) begin
            cell_written[fram_addr] <= 1'b1;
        end
    end

    // a cell never written since reset reads back as invalid.
    always_comb begin
        read_attr = cell_attr[fram_addr];
        if (!cell_written[fram_addr]) begin
            read_attr              = '0;
            read_attr[invalid_bit] = 1'b1;
        end
    end

    assign bus.data_out = bus.signal_oe ? cell_data[fram_addr] : '0;
    assign bus.attr_out = bus.signal_oe ? read_attr : '0;

endmodule

`default_nettype wire

// File: src/pu_accum.sv
`default_nettype none

module pu_accum (
    input  logic clk,
    input  logic rst,
    input  logic acc_new,
    pu_bus_if.pu bus
);
    import pu_data_pkg::*;

    data_t sum;
    logic  sum_invalid;
    data_t base;
    logic  base_invalid;
    data_t sum_next;
    logic  overflow;
    attr_t sum_attr;

    // acc_new starts from zero, so a load is an add to an empty sum.
    assign base         = acc_new ? '0 : sum;
    assign base_invalid = acc_new ? 1'b0 : sum_invalid;
    assign sum_next     = base + bus.data_in;

    // signed overflow when both operands share a sign the sum does not.
    assign overflow = (base[data_width-1] == bus.data_in[data_width-1])
                   && (sum_next[data_width-1] != base[data_width-1]);

    always_ff @(posedge clk) begin
        if (bus.signal_wr) begin
            sum <= sum_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_invalid <= 1'b0;
        end else if (bus.signal_wr) begin
            sum_invalid <= base_invalid || overflow || bus.attr_in[invalid_bit];
        end
    end

    always_comb begin
        sum_attr              = '0;
        sum_attr[invalid_bit] = sum_invalid;
    end

    assign bus.data_out = bus.signal_oe ? sum : '0;
    assign bus.attr_out = bus.signal_oe ? sum_attr : '0;

endmodule

`default_nettype wire

// File: src/pu_multiplier.sv
`default_nettype none

module pu_multiplier (
    input  logic clk,
    input  logic rst,
    pu_bus_if.pu bus
);
    import pu_data_pkg::*;

    data_t arg [2];
    logic  arg_invalid [2];
    logic  arg_sel;       // index of the next argument to be written.
    logic  second_wr;
    logic  mult_go;
    logic  load_result;

    half_t                       op_a;
    half_t                       op_b;
    logic signed [data_width-1:0] product;
    logic signed [data_width-1:0] prod_q;
    logic                        prod_invalid;
    logic                        range_err;

    data_t result;
    logic  result_invalid;
    attr_t result_attr;

    assign second_wr = bus.signal_wr && arg_sel;

    always_ff @(posedge clk) begin
        if (bus.signal_wr) begin
            arg[arg_sel]         <= bus.data_in;
            arg_invalid[arg_sel] <= bus.attr_in[invalid_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arg_sel     <= 1'b0;
            mult_go     <= 1'b0;
            load_result <= 1'b0;
        end else begin
            if (bus.signal_wr) begin
                arg_sel <= !arg_sel;
            end
            mult_go     <= second_wr;
            load_result <= mult_go;
        end
    end

    // ------------------------------------------------------------------
    // two stage pipeline that multiplies and then scales the product
    // ------------------------------------------------------------------
    assign op_a    = arg[0][half_width-1:0];
    assign op_b    = arg[1][half_width-1:0];
    assign product = op_a * op_b;

    // the upper half plus the sign bit of the low half must all agree.
    assign range_err = !((arg[0][data_width-1:half_width-1] == '0)
                      || (arg[0][data_width-1:half_width-1] == '1))
                    || !((arg[1][data_width-1:half_width-1] == '0)
                      || (arg[1][data_width-1:half_width-1] == '1));

    always_ff @(posedge clk) begin
        if (mult_go) begin
            prod_q       <= product;
            prod_invalid <= arg_invalid[0] || arg_invalid[1] || range_err;
        end
        if (load_result) begin
            result         <= data_t'(prod_q >>> scale_power);
            result_invalid <= prod_invalid;
        end
    end

    always_comb begin
        result_attr              = '0;
        result_attr[invalid_bit] = result_invalid;
    end

    assign bus.data_out = bus.signal_oe ? result : '0;
    assign bus.attr_out = bus.signal_oe ? result_attr : '0;

    a_result_not_ready: assert property (
        @(posedge clk) disable iff (rst) second_wr |=> !bus.signal_oe [*2]
    ) else $error("pu_multiplier: product read before the pipeline finished");

endmodule

`default_nettype wire

// File: src/pu_control.sv
`default_nettype none

module pu_control (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   prog_wr,
    input  pu_code_pkg::pc_t       prog_addr,
    input  pu_code_pkg::code_t     prog_data,
    input  logic                   start,
    output logic                   done,
    output pu_code_pkg::fram_addr_t fram_addr,
    output logic                   acc_new,
    pu_bus_if.ctrl                 mult_bus,
    pu_bus_if.ctrl                 accum_bus,
    pu_bus_if.ctrl                 fram_bus,
    pu_bus_if.ctrl                 io_bus
);
    import pu_code_pkg::*;
    import pu_data_pkg::*;

    code_t       prog_mem [prog_depth];
    ctrl_state_t state;
    pc_t         pc;
    code_t       word;
    logic        running;
    logic        word_stop;
    logic [unit_count-1:0] wr_strobe;
    logic [unit_count-1:0] oe_strobe;
    data_t       bus_data;
    attr_t       bus_attr;

    always_ff @(posedge clk) begin
        if (prog_wr) begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    // ------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------
    assign word      = prog_mem[pc];
    assign running   = (state == run);
    assign word_stop = running && word[code_stop_bit];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            pc    <= '0;
            done  <= 1'b0;
        end else begin
            done <= word_stop;  // one cycle after the stop word.
            case (state)
                idle: begin
                    pc <= '0;
                    if (start) begin
                        state <= run;
                    end
                end
                run: begin
                    if (word_stop) begin
                        state <= idle;
                    end else begin
                        pc <= pc + pc_t'(1);
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // decode and bus
    // ------------------------------------------------------------------
    assign wr_strobe = running ? word[code_wr_lsb +: unit_count] : '0;
    assign oe_strobe = running ? word[code_oe_lsb +: unit_count] : '0;
    assign fram_addr = word[code_fram_lsb +: $bits(fram_addr_t)];
    assign acc_new   = running && word[code_acc_new_bit];

    // idle units drive zero, so the or of all outputs is the bus value.
    assign bus_data = mult_bus.data_out | accum_bus.data_out
                    | fram_bus.data_out | io_bus.data_out;
    assign bus_attr = mult_bus.attr_out | accum_bus.attr_out
                    | fram_bus.attr_out | io_bus.attr_out;

    assign mult_bus.signal_wr  = wr_strobe[unit_mult];
    assign mult_bus.signal_oe  = oe_strobe[unit_mult];
    assign mult_bus.data_in    = bus_data;
    assign mult_bus.attr_in    = bus_attr;

    assign accum_bus.signal_wr = wr_strobe[unit_accum];
    assign accum_bus.signal_oe = oe_strobe[unit_accum];
    assign accum_bus.data_in   = bus_data;
    assign accum_bus.attr_in   = bus_attr;

    assign fram_bus.signal_wr  = wr_strobe[unit_fram];
    assign fram_bus.signal_oe  = oe_strobe[unit_fram];
    assign fram_bus.data_in    = bus_data;
    assign fram_bus.attr_in    = bus_attr;

    assign io_bus.signal_wr    = wr_strobe[unit_io];
    assign io_bus.signal_oe    = oe_strobe[unit_io];
    assign io_bus.data_in      = bus_data;
    assign io_bus.attr_in      = bus_attr;

    // two sources in one word would merge on the or bus.
    a_single_source: assert property (
        @(posedge clk) disable iff (rst) running |-> $onehot0(word[code_oe_lsb +: unit_count])
    ) else $error("pu_control: more than one oe bit set at pc %0d", pc);

endmodule

`default_nettype wire

// File: src/pu_bus_if.sv
`default_nettype none

interface pu_bus_if;
    import pu_data_pkg::*;

    logic  signal_wr;
    logic  signal_oe;
    data_t data_in;   // shared bus value seen by every unit.
    attr_t attr_in;
    data_t data_out;  // zero whenever signal_oe is low.
    attr_t attr_out;

    modport ctrl (
        output signal_wr, signal_oe, data_in, attr_in,
        input  data_out, attr_out
    );

    modport pu (
        input  signal_wr, signal_oe, data_in, attr_in,
        output data_out, attr_out
    );

endinterface

`default_nettype wire

// File: src/pu_code_pkg.sv
`default_nettype none

package pu_code_pkg;

    localparam int prog_depth = 16;
    localparam int unit_count = 4;
    localparam int fram_cells = 4;

    typedef logic [$clog2(prog_depth)-1:0] pc_t;
    typedef logic [$clog2(fram_cells)-1:0] fram_addr_t;

    // ------------------------------------------------------------------
    // microcode word layout from the lsb up
    // ------------------------------------------------------------------
    localparam int code_width       = 12;
    localparam int code_wr_lsb      = 0;   // one write strobe per unit.
    localparam int code_oe_lsb      = 4;   // one output enable per unit.
    localparam int code_fram_lsb    = 8;
    localparam int code_acc_new_bit = 10;
    localparam int code_stop_bit    = 11;

    typedef logic [code_width-1:0] code_t;

    // bit positions inside the wr and oe fields.
    localparam int unit_mult  = 0;
    localparam int unit_accum = 1;
    localparam int unit_fram  = 2;
    localparam int unit_io    = 3;

    typedef enum logic {
        idle,
        run
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: src/pu_data_pkg.sv
`default_nettype none

package pu_data_pkg;

    // ------------------------------------------------------------------
    // bus word and attribute
    // ------------------------------------------------------------------
    localparam int data_width = 32;
    localparam int attr_width = 4;
    localparam int half_width = data_width / 2;

    typedef logic [data_width-1:0] data_t;
    typedef logic [attr_width-1:0] attr_t;
    typedef logic signed [half_width-1:0] half_t;

    localparam int invalid_bit = 0;  // set when the value cannot be trusted.

    // the multiplier shifts its product right by this many bits.
    localparam int scale_power = 0;

    // host input queue of the io unit.
    localparam int queue_depth = 4;

    typedef logic [$clog2(queue_depth)-1:0] queue_ptr_t;

endpackage

`default_nettype wire
